//--- shell_config.svh
`ifndef SHELL_CONFIG_SVH
`define SHELL_CONFIG_SVH

//////////////////////////////////////////////////
// Host download stream
//////////////////////////////////////////////////

// Index the host uses for the DIP switch block
`define SHELL_DIP_INDEX  8'd254
`define SHELL_DIP_BYTES  8
// Only the low bytes reach the game
`define SHELL_DIP_USED   3

//////////////////////////////////////////////////
// Player controls
//////////////////////////////////////////////////

`define SHELL_PLAYERS    4

// Button positions in a joystick or keyboard word
`define SHELL_JOY_START  10
`define SHELL_JOY_COIN   11
`define SHELL_JOY_START2 12
`define SHELL_JOY_PAUSE  13

`endif

//--- shell_pkg.sv
`include "shell_config.svh"

package shell_pkg;

    // One player's joystick or keyboard word, buttons above bit 9
    typedef logic [15:0] joy_word_t;

    // Directions and fire buttons as the game sees them
    typedef logic [9:0] player_bits_t;

    // Used DIP bytes, byte 0 in the low bits
    typedef logic [8*`SHELL_DIP_USED-1:0] dip_word_t;

    // One term of the video aspect ratio
    typedef logic [11:0] aspect_t;

    // Byte address within a download
    typedef logic [24:0] dl_addr_t;

endpackage

//--- ioctl_if.sv
`timescale 1ns/1ps

// Download stream from the host, one byte per write strobe
interface ioctl_if import shell_pkg::*; ();

    logic       dl_active;
    logic [7:0] dl_index;
    logic       dl_wr;
    dl_addr_t   dl_addr;
    logic [7:0] dl_data;

    modport host (
        output dl_active,
        output dl_index,
        output dl_wr,
        output dl_addr,
        output dl_data
    );

    modport sink (
        input dl_active,
        input dl_index,
        input dl_wr,
        input dl_addr,
        input dl_data
    );

endinterface

//--- dip_switch_bank.sv
`timescale 1ns/1ps
`include "shell_config.svh"

module dip_switch_bank
    import shell_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_n,
    ioctl_if.sink     dl,
    output dip_word_t dip
);

    localparam int DIP_AW = $clog2(`SHELL_DIP_BYTES);

    // Switches are active low, so all ones means everything off
    logic [7:0]        dip_sw [`SHELL_DIP_BYTES];
    logic              dip_hit;
    logic [DIP_AW-1:0] dip_sel;

    // Upper address bits must be clear for the write to land in the bank
    assign dip_hit = dl.dl_wr
                  && (dl.dl_index == `SHELL_DIP_INDEX)
                  && (dl.dl_addr[$bits(dl_addr_t)-1:DIP_AW] == '0);
    assign dip_sel = dl.dl_addr[DIP_AW-1:0];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SHELL_DIP_BYTES; i++) begin
                dip_sw[i] <= 8'hff;
            end
        end else if (dip_hit) begin
            dip_sw[dip_sel] <= dl.dl_data;
        end
    end

    // Bytes past the used count are kept but never reach the game
    always_comb begin
        for (int i = 0; i < `SHELL_DIP_USED; i++) begin
            dip[8*i +: 8] = dip_sw[i];
        end
    end

endmodule

//--- player_input_mapper.sv
`timescale 1ns/1ps
`include "shell_config.svh"

module player_input_mapper
    import shell_pkg::*;
(
    input  logic         clk_sys,
    input  logic         rst_n,
    input  joy_word_t    joy_p1,
    input  joy_word_t    joy_p2,
    input  joy_word_t    joy_p3,
    input  joy_word_t    joy_p4,
    input  joy_word_t    key_p1,
    input  joy_word_t    key_p2,
    input  joy_word_t    key_p3,
    input  joy_word_t    key_p4,
    input  logic [3:0]   key_start,
    input  logic [3:0]   key_coin,
    input  logic         key_pause,
    output player_bits_t p1,
    output player_bits_t p2,
    output player_bits_t p3,
    output player_bits_t p4,
    output logic [3:0]   start,
    output logic         coin,
    output logic         pause_button
);

    localparam int PW = $bits(player_bits_t);

    joy_word_t                   joy_w  [`SHELL_PLAYERS];
    joy_word_t                   merged [`SHELL_PLAYERS];
    joy_word_t                   joy_all;
    logic [`SHELL_PLAYERS-1:0]   start_d;

    assign joy_w = '{joy_p1, joy_p2, joy_p3, joy_p4};
    assign merged = '{key_p1 | joy_p1, key_p2 | joy_p2, key_p3 | joy_p3, key_p4 | joy_p4};

    //////////////////////////////////////////////////
    // Start buttons
    //////////////////////////////////////////////////

    always_comb begin
        joy_all = '0;
        for (int i = 0; i < `SHELL_PLAYERS; i++) begin
            joy_all   = joy_all | joy_w[i];
            start_d[i] = joy_w[i][`SHELL_JOY_START] | key_start[i];
        end
        // Any pad's second start button doubles as player 2 start
        start_d[1] = start_d[1] | joy_all[`SHELL_JOY_START2];
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            p1           <= '0;
            p2           <= '0;
            p3           <= '0;
            p4           <= '0;
            start        <= '0;
            coin         <= 1'b0;
            pause_button <= 1'b0;
        end else begin
            p1           <= merged[0][PW-1:0];
            p2           <= merged[1][PW-1:0];
            p3           <= merged[2][PW-1:0];
            p4           <= merged[3][PW-1:0];
            start        <= start_d;
            coin         <= joy_all[`SHELL_JOY_COIN] | (|key_coin);
            pause_button <= joy_all[`SHELL_JOY_PAUSE] | key_pause;
        end
    end

endmodule

//--- pause_control.sv
`timescale 1ns/1ps

module pause_control (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pause_button,
    input  logic osd_pause_en,
    input  logic osd_status,
    output logic system_pause
);

    logic pause_prev;
    logic pause_rise;
    logic user_pause;
    logic user_pause_next;

    // A long press counts once
    assign pause_rise      = pause_button & ~pause_prev;
    assign user_pause_next = user_pause ^ pause_rise;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pause_prev <= 1'b0;
            user_pause <= 1'b0;
        end else begin
            pause_prev <= pause_button;
            user_pause <= user_pause_next;
        end
    end

    //////////////////////////////////////////////////
    // Pause output
    //////////////////////////////////////////////////

    // Menu pause holds the game while the OSD is open, user flag untouched
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            system_pause <= 1'b0;
        end else begin
            system_pause <= user_pause_next | (osd_pause_en & osd_status);
        end
    end

endmodule

//--- video_aspect_select.sv
`timescale 1ns/1ps

module video_aspect_select
    import shell_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic [1:0] ar_mode,
    input  logic       vertical,
    output aspect_t    arx,
    output aspect_t    ary
);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            arx <= aspect_t'(4);
            ary <= aspect_t'(3);
        end else if (ar_mode == 2'd0) begin
            // Original shape, turned on its side for a vertical screen
            if (vertical) begin
                arx <= aspect_t'(3);
                ary <= aspect_t'(4);
            end else begin
                arx <= aspect_t'(4);
                ary <= aspect_t'(3);
            end
        end else begin
            // ary of zero tells the host to use its stored ratio slot in arx
            arx <= aspect_t'(ar_mode) - aspect_t'(1);
            ary <= '0;
        end
    end

endmodule

//--- arcade_shell_top.sv
`timescale 1ns/1ps

module arcade_shell_top
    import shell_pkg::*;
(
    input  logic         clk_sys,
    input  logic         rst_n,
    input  joy_word_t    joy_p1,
    input  joy_word_t    joy_p2,
    input  joy_word_t    joy_p3,
    input  joy_word_t    joy_p4,
    input  joy_word_t    key_p1,
    input  joy_word_t    key_p2,
    input  joy_word_t    key_p3,
    input  joy_word_t    key_p4,
    input  logic [3:0]   key_start,
    input  logic [3:0]   key_coin,
    input  logic         key_pause,
    input  logic         osd_pause_en,
    input  logic         osd_status,
    input  logic [1:0]   ar_mode,
    input  logic         vertical,
    input  logic         dl_active,
    input  logic [7:0]   dl_index,
    input  logic         dl_wr,
    input  dl_addr_t     dl_addr,
    input  logic [7:0]   dl_data,
    output dip_word_t    dip,
    output player_bits_t p1,
    output player_bits_t p2,
    output player_bits_t p3,
    output player_bits_t p4,
    output logic [3:0]   start,
    output logic         coin,
    output logic         system_pause,
    output aspect_t      arx,
    output aspect_t      ary
);

    logic pause_button;

    //////////////////////////////////////////////////
    // Download stream
    //////////////////////////////////////////////////

    ioctl_if dl_bus ();

    assign dl_bus.dl_active = dl_active;
    assign dl_bus.dl_index  = dl_index;
    assign dl_bus.dl_wr     = dl_wr;
    assign dl_bus.dl_addr   = dl_addr;
    assign dl_bus.dl_data   = dl_data;

    dip_switch_bank u_dip (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .dl      (dl_bus.sink),
        .dip     (dip)
    );

    //////////////////////////////////////////////////
    // Controls and video
    //////////////////////////////////////////////////

    player_input_mapper u_inputs (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .joy_p1       (joy_p1),
        .joy_p2       (joy_p2),
        .joy_p3       (joy_p3),
        .joy_p4       (joy_p4),
        .key_p1       (key_p1),
        .key_p2       (key_p2),
        .key_p3       (key_p3),
        .key_p4       (key_p4),
        .key_start    (key_start),
        .key_coin     (key_coin),
        .key_pause    (key_pause),
        .p1           (p1),
        .p2           (p2),
        .p3           (p3),
        .p4           (p4),
        .start        (start),
        .coin         (coin),
        .pause_button (pause_button)
    );

    // Pause sees the registered button, hence two cycles end to end
    pause_control u_pause (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .pause_button (pause_button),
        .osd_pause_en (osd_pause_en),
        .osd_status   (osd_status),
        .system_pause (system_pause)
    );

    video_aspect_select u_aspect (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .ar_mode  (ar_mode),
        .vertical (vertical),
        .arx      (arx),
        .ary      (ary)
    );

endmodule

//--- arcade_shell_asserts.sv
`timescale 1ns/1ps
`include "shell_config.svh"

module arcade_shell_asserts
    import shell_pkg::*;
(
    input logic       clk_sys,
    input logic       rst_n,
    input joy_word_t  joy_p1,
    input joy_word_t  joy_p2,
    input joy_word_t  joy_p3,
    input joy_word_t  joy_p4,
    input logic [3:0] key_coin,
    input logic       coin,
    input logic [1:0] ar_mode,
    input aspect_t    ary,
    input logic       system_pause
);

    int   fail_count = 0;
    logic coin_src;

    assign coin_src = joy_p1[`SHELL_JOY_COIN] | joy_p2[`SHELL_JOY_COIN]
                    | joy_p3[`SHELL_JOY_COIN] | joy_p4[`SHELL_JOY_COIN] | (|key_coin);

    pause_low_after_reset: assert property (
        @(posedge clk_sys) $rose(rst_n) |-> !system_pause
    ) else begin
        fail_count++;
        $error("system_pause high in the first cycle after reset");
    end

    coin_has_source: assert property (
        @(posedge clk_sys) disable iff (!rst_n) coin |-> $past(coin_src)
    ) else begin
        fail_count++;
        $error("coin high without a coin source one cycle earlier");
    end

    // Custom ratio slot selected
    custom_ratio_ary_zero: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        ($past(rst_n) && $past(ar_mode) != 2'd0) |-> (ary == '0)
    ) else begin
        fail_count++;
        $error("ary nonzero after a nonzero ar_mode");
    end

endmodule

bind arcade_shell_top arcade_shell_asserts u_asserts (.*);

//--- tb_checker.sv
`timescale 1ns/1ps
`include "shell_config.svh"

module tb_checker
    import shell_pkg::*;
(
    input  logic         clk_sys,
    input  logic         rst_n,
    input  joy_word_t    joy_p1,
    input  joy_word_t    joy_p2,
    input  joy_word_t    joy_p3,
    input  joy_word_t    joy_p4,
    input  joy_word_t    key_p1,
    input  joy_word_t    key_p2,
    input  joy_word_t    key_p3,
    input  joy_word_t    key_p4,
    input  logic [3:0]   key_start,
    input  logic [3:0]   key_coin,
    input  logic         key_pause,
    input  logic         osd_pause_en,
    input  logic         osd_status,
    input  logic [1:0]   ar_mode,
    input  logic         vertical,
    input  logic [7:0]   dl_index,
    input  logic         dl_wr,
    input  dl_addr_t     dl_addr,
    input  logic [7:0]   dl_data,
    input  dip_word_t    dip,
    input  player_bits_t p1,
    input  player_bits_t p2,
    input  player_bits_t p3,
    input  player_bits_t p4,
    input  logic [3:0]   start,
    input  logic         coin,
    input  logic         system_pause,
    input  aspect_t      arx,
    input  aspect_t      ary,
    output int           check_count,
    output int           error_count
);

    logic [7:0]   m_dip [`SHELL_DIP_USED];
    player_bits_t m_p [`SHELL_PLAYERS];
    logic [3:0]   m_start;
    logic         m_coin;
    // Registered pause button and its previous sample
    logic         m_btn;
    logic         m_btn_prev;
    logic         m_user;
    logic         m_pause;
    aspect_t      m_arx;
    aspect_t      m_ary;
    logic         seen_reset = 1'b0;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s expected %h got %h", name, exp, got);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model, one step per clock
    //////////////////////////////////////////////////

    always @(posedge clk_sys or negedge rst_n) begin : model_step
        joy_word_t jw [`SHELL_PLAYERS];
        joy_word_t kw [`SHELL_PLAYERS];
        joy_word_t jall;
        logic      rise;
        if (!rst_n) begin
            for (int i = 0; i < `SHELL_DIP_USED; i++) begin
                m_dip[i] = 8'hff;
            end
            for (int i = 0; i < `SHELL_PLAYERS; i++) begin
                m_p[i] = '0;
            end
            {m_start, m_coin, m_btn, m_btn_prev, m_user, m_pause} = '0;
            m_arx      = aspect_t'(4);
            m_ary      = aspect_t'(3);
            seen_reset = 1'b1;
        end else begin
            // Only the visible bytes matter, higher slots never show
            if (dl_wr && dl_index == `SHELL_DIP_INDEX
                && dl_addr < dl_addr_t'(`SHELL_DIP_USED)) begin
                m_dip[dl_addr[1:0]] = dl_data;
            end
            jw   = '{joy_p1, joy_p2, joy_p3, joy_p4};
            kw   = '{key_p1, key_p2, key_p3, key_p4};
            jall = joy_p1 | joy_p2 | joy_p3 | joy_p4;
            for (int i = 0; i < `SHELL_PLAYERS; i++) begin
                m_p[i]     = player_bits_t'(jw[i] | kw[i]);
                m_start[i] = jw[i][`SHELL_JOY_START] | key_start[i];
            end
            m_start[1] = m_start[1] | jall[`SHELL_JOY_START2];
            m_coin     = jall[`SHELL_JOY_COIN] | (|key_coin);
            // Pause sees the button one stage late
            rise       = m_btn & ~m_btn_prev;
            m_user     = m_user ^ rise;
            m_pause    = m_user | (osd_pause_en & osd_status);
            m_btn_prev = m_btn;
            m_btn      = jall[`SHELL_JOY_PAUSE] | key_pause;
            if (ar_mode == 2'd0) begin
                m_arx = vertical ? aspect_t'(3) : aspect_t'(4);
                m_ary = vertical ? aspect_t'(4) : aspect_t'(3);
            end else begin
                // Host ratio slots count from zero, modes from one
                case (ar_mode)
                    2'd1:    m_arx = aspect_t'(0);
                    2'd2:    m_arx = aspect_t'(1);
                    default: m_arx = aspect_t'(2);
                endcase
                m_ary = '0;
            end
        end
    end

    // Outputs are steady at the falling edge
    always @(negedge clk_sys) begin
        if (seen_reset) begin
            compare("dip", 32'({m_dip[2], m_dip[1], m_dip[0]}), 32'(dip));
            compare("p1", 32'(m_p[0]), 32'(p1));
            compare("p2", 32'(m_p[1]), 32'(p2));
            compare("p3", 32'(m_p[2]), 32'(p3));
            compare("p4", 32'(m_p[3]), 32'(p4));
            compare("start", 32'(m_start), 32'(start));
            compare("coin", 32'(m_coin), 32'(coin));
            compare("system_pause", 32'(m_pause), 32'(system_pause));
            compare("arx", 32'(m_arx), 32'(arx));
            compare("ary", 32'(m_ary), 32'(ary));
        end
    end

endmodule

//--- tb_arcade_shell.sv
`timescale 1ns/1ps
`include "shell_config.svh"

module tb_arcade_shell
    import shell_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES   = 2000;
    // Reset, random run and drain, with room to spare
    localparam int CYCLE_LIMIT  = RESET_CYCLES + RUN_CYCLES + 496;

    logic         clk_sys = 1'b0;
    logic         rst_n;
    joy_word_t    joy_p1;
    joy_word_t    joy_p2;
    joy_word_t    joy_p3;
    joy_word_t    joy_p4;
    joy_word_t    key_p1;
    joy_word_t    key_p2;
    joy_word_t    key_p3;
    joy_word_t    key_p4;
    logic [3:0]   key_start;
    logic [3:0]   key_coin;
    logic         key_pause;
    logic         osd_pause_en;
    logic         osd_status;
    logic [1:0]   ar_mode;
    logic         vertical;
    logic         dl_active;
    logic [7:0]   dl_index;
    logic         dl_wr;
    dl_addr_t     dl_addr;
    logic [7:0]   dl_data;
    dip_word_t    dip;
    player_bits_t p1;
    player_bits_t p2;
    player_bits_t p3;
    player_bits_t p4;
    logic [3:0]   start;
    logic         coin;
    logic         system_pause;
    aspect_t      arx;
    aspect_t      ary;
    int           check_count;
    int           error_count;
    int           cycle_count = 0;
    int           pause_hold;
    logic         pause_on_key;
    logic [1:0]   pause_pad;

    arcade_shell_top i_arcade_shell_top (.*);

    tb_checker i_checker (.*);

    always #20 clk_sys = ~clk_sys;

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic clear_inputs();
        {joy_p1, joy_p2, joy_p3, joy_p4} = '0;
        {key_p1, key_p2, key_p3, key_p4} = '0;
        key_start    = 4'd0;
        key_coin     = 4'd0;
        key_pause    = 1'b0;
        osd_pause_en = 1'b0;
        osd_status   = 1'b0;
        ar_mode      = 2'd0;
        vertical     = 1'b0;
        dl_active    = 1'b0;
        dl_index     = 8'd0;
        dl_wr        = 1'b0;
        dl_addr      = '0;
        dl_data      = 8'd0;
    endtask

    // Mostly idle pad, pause bit left to the press logic
    function automatic joy_word_t rare_word();
        logic [31:0] r;
        joy_word_t   w;
        r = $urandom;
        w = '0;
        if (r[19:16] == 4'd0) begin
            w = r[15:0];
        end
        w[`SHELL_JOY_PAUSE] = 1'b0;
        return w;
    endfunction

    task automatic press_pause();
        logic [31:0] r;
        r = $urandom;
        if (pause_hold > 0) begin
            pause_hold = pause_hold - 1;
        end else if (r[5:0] == 6'd0) begin
            // Some presses are held for several cycles
            pause_hold   = 1 + int'(r[8:6]);
            pause_on_key = r[9];
            pause_pad    = r[11:10];
        end
        key_pause = pause_on_key && (pause_hold > 0);
        if (!pause_on_key && (pause_hold > 0)) begin
            case (pause_pad)
                2'd0:    joy_p1[`SHELL_JOY_PAUSE] = 1'b1;
                2'd1:    joy_p2[`SHELL_JOY_PAUSE] = 1'b1;
                2'd2:    joy_p3[`SHELL_JOY_PAUSE] = 1'b1;
                default: joy_p4[`SHELL_JOY_PAUSE] = 1'b1;
            endcase
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = $urandom;
        joy_p1 = rare_word();
        joy_p2 = rare_word();
        joy_p3 = rare_word();
        joy_p4 = rare_word();
        key_p1 = rare_word();
        key_p2 = rare_word();
        key_p3 = rare_word();
        key_p4 = rare_word();
        key_start    = (r[3:0] == 4'd0) ? r[7:4] : 4'd0;
        key_coin     = (r[11:8] == 4'd0) ? r[15:12] : 4'd0;
        osd_pause_en = r[16];
        osd_status   = (r[21:17] == 5'd0);
        if (r[26:22] == 5'd0) begin
            ar_mode  = r[28:27];
            vertical = r[29];
        end
        press_pause();
        // Download writes, half of them aimed at the DIP block
        r = $urandom;
        dl_wr     = (r[1:0] == 2'd0);
        dl_active = dl_wr | r[2];
        dl_index  = r[3] ? `SHELL_DIP_INDEX : r[11:4];
        dl_addr   = dl_addr_t'(r[15:12]);
        dl_data   = r[23:16];
    endtask

    task automatic report_counts();
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, i_arcade_shell_top.u_asserts.fail_count);
    endtask

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hfc70));
        rst_n        = 1'b0;
        pause_hold   = 0;
        pause_on_key = 1'b1;
        pause_pad    = 2'd0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_n = 1'b1;
        for (int i = 0; i < RUN_CYCLES; i++) begin
            @(negedge clk_sys);
            drive_random();
        end
        @(negedge clk_sys);
        clear_inputs();
        repeat (4) @(negedge clk_sys);
        report_counts();
        if (error_count == 0 && check_count > 0
            && i_arcade_shell_top.u_asserts.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles without finishing", cycle_count);
            report_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+.
shell_pkg.sv
ioctl_if.sv
dip_switch_bank.sv
player_input_mapper.sv
pause_control.sv
video_aspect_select.sv
arcade_shell_top.sv
arcade_shell_asserts.sv
tb_checker.sv
tb_arcade_shell.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_arcade_shell
FLAGS     ?= --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
